// File: src/harness_cfg.svh
//////////////////////////////
// Harness configuration constants
// Bank count, bank depth and wait states
//////////////////////////////

`ifndef HARNESS_CFG_SVH
`define HARNESS_CFG_SVH

// Interleaved banks, selected by address bits 3:2
`define HARNESS_NUM_BANKS 4

// Words per bank, word index from address bits 10:4
`define HARNESS_BANK_WORDS 128

// Upper bound on grant wait states per access
`define HARNESS_MAX_WAIT 3

`endif

// File: src/harness_pkg.sv
//////////////////////////////
// Shared types of the harness
// Bus words, byte enables, owner ids
//////////////////////////////

package harness_pkg;

  // Bus address or data word
  typedef logic [31:0] word_t;

  // One enable per byte lane
  typedef logic [3:0] be_t;

  // Copy engine register offset
  typedef logic [3:0] reg_addr_t;

  // Which master holds a bank
  typedef enum logic {
    MASTER_HOST = 1'b0,
    MASTER_DMA  = 1'b1
  } master_id_e;

endpackage

// File: src/slow_memory.sv
//////////////////////////////
// Slow memory bank
// Byte-enable RAM with random grant delay
//////////////////////////////

`include "harness_cfg.svh"

module slow_memory #(
  parameter int unsigned num_words_p = `HARNESS_BANK_WORDS,
  parameter int unsigned bank_idx_p  = 0
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [$clog2(num_words_p)-1:0] addr_i,
  input  harness_pkg::word_t             wdata_i,
  input  harness_pkg::be_t               be_i,
  output logic                           gnt_o,
  output logic                           rvalid_o,
  output harness_pkg::word_t             rdata_o
);

  localparam int unsigned wait_w_lp = $clog2(`HARNESS_MAX_WAIT + 1);

  // Distinct start value per bank so banks stall independently
  localparam logic [7:0] lfsr_seed_lp = 8'hA5 ^ 8'(bank_idx_p);

  harness_pkg::word_t mem_q [num_words_p];

  logic [7:0]           lfsr_q;
  logic                 lfsr_fb;
  logic [wait_w_lp-1:0] wait_cnt_q;
  logic [wait_w_lp-1:0] wait_target_q;
  logic                 rvalid_q;
  harness_pkg::word_t   rdata_q;

  // Taps for x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  // Grant once the request has waited the drawn number of cycles
  assign gnt_o = req_i && (wait_cnt_q == wait_target_q);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lfsr_q        <= lfsr_seed_lp;
      wait_cnt_q    <= '0;
      wait_target_q <= '0;
      rvalid_q      <= 1'b0;
    end else begin
      rvalid_q <= gnt_o;
      if (gnt_o) begin
        // Draw the wait count for the next access
        lfsr_q        <= {lfsr_q[6:0], lfsr_fb};
        wait_target_q <= wait_w_lp'(lfsr_q % (`HARNESS_MAX_WAIT + 1));
        wait_cnt_q    <= '0;
      end else if (req_i) begin
        wait_cnt_q <= wait_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      if (we_i) begin
        for (int i = 0; i < 4; i++) begin
          if (be_i[i]) begin
            mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

// File: src/obi_bank_router.sv
//////////////////////////////
// Bank router for two bus masters
// Bank decode and round-robin arbitration
//////////////////////////////

`include "harness_cfg.svh"

module obi_bank_router (
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,
  input  logic                                                 host_req_i,
  input  logic                                                 host_we_i,
  input  harness_pkg::word_t                                   host_addr_i,
  input  harness_pkg::word_t                                   host_wdata_i,
  input  harness_pkg::be_t                                     host_be_i,
  output logic                                                 host_gnt_o,
  input  logic                                                 dma_req_i,
  input  logic                                                 dma_we_i,
  input  harness_pkg::word_t                                   dma_addr_i,
  input  harness_pkg::word_t                                   dma_wdata_i,
  input  harness_pkg::be_t                                     dma_be_i,
  output logic                                                 dma_gnt_o,
  output logic                   [`HARNESS_NUM_BANKS-1:0]      bank_req_o,
  output logic                   [`HARNESS_NUM_BANKS-1:0]      bank_we_o,
  output harness_pkg::word_t     [`HARNESS_NUM_BANKS-1:0]      bank_addr_o,
  output harness_pkg::word_t     [`HARNESS_NUM_BANKS-1:0]      bank_wdata_o,
  output harness_pkg::be_t       [`HARNESS_NUM_BANKS-1:0]      bank_be_o,
  input  logic                   [`HARNESS_NUM_BANKS-1:0]      bank_gnt_i,
  input  logic                   [`HARNESS_NUM_BANKS-1:0]      bank_rvalid_i,
  output harness_pkg::master_id_e [`HARNESS_NUM_BANKS-1:0]     bank_owner_o
);

  localparam int unsigned sel_w_lp = $clog2(`HARNESS_NUM_BANKS);

  logic [sel_w_lp-1:0] host_bank;
  logic [sel_w_lp-1:0] dma_bank;

  // Request offered to a bank, per master
  logic [`HARNESS_NUM_BANKS-1:0] host_hit;
  logic [`HARNESS_NUM_BANKS-1:0] dma_hit;
  // Request actually forwarded after arbitration
  logic [`HARNESS_NUM_BANKS-1:0] host_fwd;
  logic [`HARNESS_NUM_BANKS-1:0] dma_fwd;

  logic                    [`HARNESS_NUM_BANKS-1:0] owner_valid_q;
  harness_pkg::master_id_e [`HARNESS_NUM_BANKS-1:0] owner_q;
  // Master that wins the next same-bank conflict
  harness_pkg::master_id_e [`HARNESS_NUM_BANKS-1:0] rr_q;

  assign host_bank = host_addr_i[2 +: sel_w_lp];
  assign dma_bank  = dma_addr_i[2 +: sel_w_lp];

  always_comb begin
    host_gnt_o = 1'b0;
    dma_gnt_o  = 1'b0;
    for (int b = 0; b < `HARNESS_NUM_BANKS; b++) begin
      // Owned banks are not offered until their response returns
      host_hit[b] = host_req_i && (host_bank == sel_w_lp'(b)) && !owner_valid_q[b];
      dma_hit[b]  = dma_req_i && (dma_bank == sel_w_lp'(b)) && !owner_valid_q[b];

      dma_fwd[b]  = dma_hit[b] && (!host_hit[b] || rr_q[b] == harness_pkg::MASTER_DMA);
      host_fwd[b] = host_hit[b] && !dma_fwd[b];

      bank_req_o[b] = host_fwd[b] || dma_fwd[b];
      if (dma_fwd[b]) begin
        bank_we_o[b]    = dma_we_i;
        bank_addr_o[b]  = dma_addr_i;
        bank_wdata_o[b] = dma_wdata_i;
        bank_be_o[b]    = dma_be_i;
      end else begin
        bank_we_o[b]    = host_we_i;
        bank_addr_o[b]  = host_addr_i;
        bank_wdata_o[b] = host_wdata_i;
        bank_be_o[b]    = host_be_i;
      end

      host_gnt_o = host_gnt_o || (bank_gnt_i[b] && host_fwd[b]);
      dma_gnt_o  = dma_gnt_o || (bank_gnt_i[b] && dma_fwd[b]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owner_valid_q <= '0;
      owner_q       <= {`HARNESS_NUM_BANKS{harness_pkg::MASTER_HOST}};
      rr_q          <= {`HARNESS_NUM_BANKS{harness_pkg::MASTER_HOST}};
    end else begin
      for (int b = 0; b < `HARNESS_NUM_BANKS; b++) begin
        if (bank_req_o[b] && bank_gnt_i[b]) begin
          owner_valid_q[b] <= 1'b1;
          if (dma_fwd[b]) begin
            owner_q[b] <= harness_pkg::MASTER_DMA;
            rr_q[b]    <= harness_pkg::MASTER_HOST;
          end else begin
            owner_q[b] <= harness_pkg::MASTER_HOST;
            rr_q[b]    <= harness_pkg::MASTER_DMA;
          end
        end else if (bank_rvalid_i[b]) begin
          owner_valid_q[b] <= 1'b0;
        end
      end
    end
  end

  assign bank_owner_o = owner_q;

endmodule

// File: src/obi_resp_merge.sv
//////////////////////////////
// Response merge
// Routes bank responses to their owners
//////////////////////////////

`include "harness_cfg.svh"

module obi_resp_merge (
  input  logic                                             clk_i,
  input  logic                                             reset_i,
  input  logic                    [`HARNESS_NUM_BANKS-1:0] bank_rvalid_i,
  input  harness_pkg::word_t      [`HARNESS_NUM_BANKS-1:0] bank_rdata_i,
  input  harness_pkg::master_id_e [`HARNESS_NUM_BANKS-1:0] bank_owner_i,
  output logic                                             host_rvalid_o,
  output harness_pkg::word_t                               host_rdata_o,
  output logic                                             dma_rvalid_o,
  output harness_pkg::word_t                               dma_rdata_o
);

  logic               host_valid;
  harness_pkg::word_t host_data;
  logic               dma_valid;
  harness_pkg::word_t dma_data;

  logic               host_rvalid_q;
  harness_pkg::word_t host_rdata_q;
  logic               dma_rvalid_q;
  harness_pkg::word_t dma_rdata_q;

  // OR-select, since one master has at most one bank responding
  function automatic void pick_resp(input harness_pkg::master_id_e id,
                                    output logic valid, output harness_pkg::word_t data);
    valid = 1'b0;
    data  = '0;
    for (int b = 0; b < `HARNESS_NUM_BANKS; b++) begin
      if (bank_rvalid_i[b] && bank_owner_i[b] == id) begin
        valid = 1'b1;
        data  = data | bank_rdata_i[b];
      end
    end
  endfunction

  always_comb begin
    pick_resp(harness_pkg::MASTER_HOST, host_valid, host_data);
    pick_resp(harness_pkg::MASTER_DMA, dma_valid, dma_data);
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      host_rvalid_q <= 1'b0;
      dma_rvalid_q  <= 1'b0;
    end else begin
      host_rvalid_q <= host_valid;
      dma_rvalid_q  <= dma_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (host_valid) host_rdata_q <= host_data;
    if (dma_valid) dma_rdata_q <= dma_data;
  end

  assign host_rvalid_o = host_rvalid_q;
  assign host_rdata_o  = host_rdata_q;
  assign dma_rvalid_o  = dma_rvalid_q;
  assign dma_rdata_o   = dma_rdata_q;

endmodule

// File: src/memcopy_periph.sv
//////////////////////////////
// Memory copy engine
// Register-programmed word copy over the bus
//////////////////////////////

module memcopy_periph (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  harness_pkg::reg_addr_t reg_addr_i,
  input  harness_pkg::word_t     reg_wdata_i,
  output harness_pkg::word_t     reg_rdata_o,
  output logic                   reg_ready_o,
  output logic                   master_req_o,
  output logic                   master_we_o,
  output harness_pkg::word_t     master_addr_o,
  output harness_pkg::word_t     master_wdata_o,
  output harness_pkg::be_t       master_be_o,
  input  logic                   master_gnt_i,
  input  logic                   master_rvalid_i,
  input  harness_pkg::word_t     master_rdata_i
);

  localparam harness_pkg::reg_addr_t reg_src_lp  = 4'h0;
  localparam harness_pkg::reg_addr_t reg_dst_lp  = 4'h4;
  localparam harness_pkg::reg_addr_t reg_size_lp = 4'h8;
  localparam harness_pkg::reg_addr_t reg_ctrl_lp = 4'hC;

  typedef enum logic [2:0] {
    IDLE,
    RD_REQ,
    RD_WAIT,
    WR_REQ,
    WR_WAIT
  } state_e;

  state_e             state_q;
  logic               busy;
  logic               reg_wr;
  logic               start_copy;
  logic               reg_ready_q;
  harness_pkg::word_t reg_rdata_q;

  // Programmed values
  harness_pkg::word_t src_q;
  harness_pkg::word_t dst_q;
  harness_pkg::word_t size_q;

  // Running copy position
  harness_pkg::word_t cur_src_q;
  harness_pkg::word_t cur_dst_q;
  harness_pkg::word_t count_q;
  harness_pkg::word_t data_q;

  assign busy   = (state_q != IDLE);
  // Writes during a copy are dropped but still acknowledged
  assign reg_wr = reg_valid_i && reg_write_i && !busy;
  // Zero size never leaves idle
  assign start_copy = reg_wr && (reg_addr_i == reg_ctrl_lp) && reg_wdata_i[0] &&
                      (size_q != '0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= IDLE;
      reg_ready_q <= 1'b0;
      src_q       <= '0;
      dst_q       <= '0;
      size_q      <= '0;
      count_q     <= '0;
    end else begin
      reg_ready_q <= reg_valid_i;
      if (reg_wr) begin
        case (reg_addr_i)
          reg_src_lp:  src_q <= reg_wdata_i;
          reg_dst_lp:  dst_q <= reg_wdata_i;
          reg_size_lp: size_q <= reg_wdata_i;
          default: ;
        endcase
      end
      case (state_q)
        IDLE: begin
          if (start_copy) begin
            count_q <= size_q;
            state_q <= RD_REQ;
          end
        end
        RD_REQ:  if (master_gnt_i) state_q <= RD_WAIT;
        RD_WAIT: if (master_rvalid_i) state_q <= WR_REQ;
        WR_REQ:  if (master_gnt_i) state_q <= WR_WAIT;
        WR_WAIT: begin
          if (master_rvalid_i) begin
            count_q <= count_q - 1'b1;
            state_q <= (count_q == 32'd1) ? IDLE : RD_REQ;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_copy) begin
      cur_src_q <= src_q;
      cur_dst_q <= dst_q;
    end else if (state_q == WR_WAIT && master_rvalid_i) begin
      cur_src_q <= cur_src_q + 32'd4;
      cur_dst_q <= cur_dst_q + 32'd4;
    end
    if (state_q == RD_WAIT && master_rvalid_i) begin
      data_q <= master_rdata_i;
    end
    if (reg_valid_i && !reg_write_i) begin
      case (reg_addr_i)
        reg_src_lp:  reg_rdata_q <= src_q;
        reg_dst_lp:  reg_rdata_q <= dst_q;
        reg_size_lp: reg_rdata_q <= size_q;
        reg_ctrl_lp: reg_rdata_q <= {31'd0, busy};
        default:     reg_rdata_q <= '0;
      endcase
    end
  end

  assign reg_ready_o = reg_ready_q;
  assign reg_rdata_o = reg_rdata_q;

  // Full-word accesses only
  assign master_req_o   = (state_q == RD_REQ) || (state_q == WR_REQ);
  assign master_we_o    = (state_q == WR_REQ);
  assign master_addr_o  = (state_q == WR_REQ) ? cur_dst_q : cur_src_q;
  assign master_wdata_o = data_q;
  assign master_be_o    = 4'hF;

endmodule

// File: src/testharness.sv
//////////////////////////////
// Test harness top level
// Host port, copy engine, banked memory
//////////////////////////////

`include "harness_cfg.svh"

module testharness (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   host_req_i,
  input  logic                   host_we_i,
  input  harness_pkg::word_t     host_addr_i,
  input  harness_pkg::word_t     host_wdata_i,
  input  harness_pkg::be_t       host_be_i,
  output logic                   host_gnt_o,
  output logic                   host_rvalid_o,
  output harness_pkg::word_t     host_rdata_o,
  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  harness_pkg::reg_addr_t reg_addr_i,
  input  harness_pkg::word_t     reg_wdata_i,
  output harness_pkg::word_t     reg_rdata_o,
  output logic                   reg_ready_o
);

  localparam int unsigned word_w_lp = $clog2(`HARNESS_BANK_WORDS);

  // Copy engine master port
  logic               dma_req;
  logic               dma_we;
  harness_pkg::word_t dma_addr;
  harness_pkg::word_t dma_wdata;
  harness_pkg::be_t   dma_be;
  logic               dma_gnt;
  logic               dma_rvalid;
  harness_pkg::word_t dma_rdata;

  // Per-bank ports
  logic                    [`HARNESS_NUM_BANKS-1:0] bank_req;
  logic                    [`HARNESS_NUM_BANKS-1:0] bank_we;
  harness_pkg::word_t      [`HARNESS_NUM_BANKS-1:0] bank_addr;
  harness_pkg::word_t      [`HARNESS_NUM_BANKS-1:0] bank_wdata;
  harness_pkg::be_t        [`HARNESS_NUM_BANKS-1:0] bank_be;
  logic                    [`HARNESS_NUM_BANKS-1:0] bank_gnt;
  logic                    [`HARNESS_NUM_BANKS-1:0] bank_rvalid;
  harness_pkg::word_t      [`HARNESS_NUM_BANKS-1:0] bank_rdata;
  harness_pkg::master_id_e [`HARNESS_NUM_BANKS-1:0] bank_owner;

  memcopy_periph i_memcopy (
    .clk_i,
    .reset_i,
    .reg_valid_i,
    .reg_write_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .reg_ready_o,
    .master_req_o   (dma_req),
    .master_we_o    (dma_we),
    .master_addr_o  (dma_addr),
    .master_wdata_o (dma_wdata),
    .master_be_o    (dma_be),
    .master_gnt_i   (dma_gnt),
    .master_rvalid_i(dma_rvalid),
    .master_rdata_i (dma_rdata)
  );

  obi_bank_router i_router (
    .clk_i,
    .reset_i,
    .host_req_i,
    .host_we_i,
    .host_addr_i,
    .host_wdata_i,
    .host_be_i,
    .host_gnt_o,
    .dma_req_i    (dma_req),
    .dma_we_i     (dma_we),
    .dma_addr_i   (dma_addr),
    .dma_wdata_i  (dma_wdata),
    .dma_be_i     (dma_be),
    .dma_gnt_o    (dma_gnt),
    .bank_req_o   (bank_req),
    .bank_we_o    (bank_we),
    .bank_addr_o  (bank_addr),
    .bank_wdata_o (bank_wdata),
    .bank_be_o    (bank_be),
    .bank_gnt_i   (bank_gnt),
    .bank_rvalid_i(bank_rvalid),
    .bank_owner_o (bank_owner)
  );

  // Word index within a bank starts above the bank select bits
  for (genvar b = 0; b < `HARNESS_NUM_BANKS; b++) begin : gen_bank
    slow_memory #(
      .num_words_p(`HARNESS_BANK_WORDS),
      .bank_idx_p (b)
    ) i_bank (
      .clk_i,
      .reset_i,
      .req_i   (bank_req[b]),
      .we_i    (bank_we[b]),
      .addr_i  (bank_addr[b][4 +: word_w_lp]),
      .wdata_i (bank_wdata[b]),
      .be_i    (bank_be[b]),
      .gnt_o   (bank_gnt[b]),
      .rvalid_o(bank_rvalid[b]),
      .rdata_o (bank_rdata[b])
    );
  end

  obi_resp_merge i_merge (
    .clk_i,
    .reset_i,
    .bank_rvalid_i(bank_rvalid),
    .bank_rdata_i (bank_rdata),
    .bank_owner_i (bank_owner),
    .host_rvalid_o,
    .host_rdata_o,
    .dma_rvalid_o (dma_rvalid),
    .dma_rdata_o  (dma_rdata)
  );

endmodule

// File: tb/tb_host_tasks.svh
//////////////////////////////
// Host bus and register port access tasks
//////////////////////////////

`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// One host bus access, also checks gnt to rvalid latency
task automatic host_access(input logic we, input harness_pkg::word_t addr,
                           input harness_pkg::word_t wdata, input harness_pkg::be_t be,
                           output harness_pkg::word_t rdata);
  int unsigned cycles;
  @(negedge clk);
  host_req   = 1'b1;
  host_we    = we;
  host_addr  = addr;
  host_wdata = wdata;
  host_be    = be;
  cycles     = 0;
  #settle_c;
  while (!host_gnt) begin
    if (cycles >= timeout_c) begin
      $display("Timed out waiting for host gnt at address %h", addr);
      stop_on_failure();
    end else begin
      cycles++;
      @(negedge clk);
      #settle_c;
    end
  end
  // Request accepted at the coming rising edge
  @(negedge clk);
  host_req = 1'b0;
  host_we  = 1'b0;
  cycles   = 1;
  #settle_c;
  while (!host_rvalid) begin
    if (cycles >= timeout_c) begin
      $display("Timed out waiting for host rvalid at address %h", addr);
      stop_on_failure();
    end else begin
      cycles++;
      @(negedge clk);
      #settle_c;
    end
  end
  check_value("host gnt to rvalid cycles", 32'd2, cycles);
  rdata = host_rdata;
endtask

// One copy engine register access, ack expected one cycle later
task automatic reg_access(input logic write, input harness_pkg::reg_addr_t addr,
                          input harness_pkg::word_t wdata, output harness_pkg::word_t rdata);
  int unsigned cycles;
  @(negedge clk);
  reg_valid = 1'b1;
  reg_write = write;
  reg_addr  = addr;
  reg_wdata = wdata;
  @(negedge clk);
  reg_valid = 1'b0;
  reg_write = 1'b0;
  cycles    = 1;
  #settle_c;
  while (!reg_ready) begin
    if (cycles >= timeout_c) begin
      $display("Timed out waiting for register ready at offset %h", addr);
      stop_on_failure();
    end else begin
      cycles++;
      @(negedge clk);
      #settle_c;
    end
  end
  check_value("register ack cycles", 32'd1, cycles);
  rdata = reg_rdata;
endtask

`endif

// File: tb/tb_testharness.sv
//////////////////////////////
// Testbench of the test harness
// Random host traffic and block copies
//////////////////////////////

`include "harness_cfg.svh"

module tb_testharness;

  localparam int unsigned mem_words_c  = `HARNESS_NUM_BANKS * `HARNESS_BANK_WORDS;
  localparam int unsigned timeout_c    = 100;
  localparam int unsigned poll_limit_c = 1000;
  localparam int unsigned settle_c     = 1;

  // Copy engine register offsets
  localparam harness_pkg::reg_addr_t reg_src_c  = 4'h0;
  localparam harness_pkg::reg_addr_t reg_dst_c  = 4'h4;
  localparam harness_pkg::reg_addr_t reg_size_c = 4'h8;
  localparam harness_pkg::reg_addr_t reg_ctrl_c = 4'hC;

  logic                   clk;
  logic                   reset;
  logic                   host_req;
  logic                   host_we;
  harness_pkg::word_t     host_addr;
  harness_pkg::word_t     host_wdata;
  harness_pkg::be_t       host_be;
  logic                   host_gnt;
  logic                   host_rvalid;
  harness_pkg::word_t     host_rdata;
  logic                   reg_valid;
  logic                   reg_write;
  harness_pkg::reg_addr_t reg_addr;
  harness_pkg::word_t     reg_wdata;
  harness_pkg::word_t     reg_rdata;
  logic                   reg_ready;

  logic [15:0]        lfsr;
  // Reference memory indexed by address bits 10:2
  harness_pkg::word_t model [mem_words_c];

  testharness i_dut (
    .clk_i        (clk),
    .reset_i      (reset),
    .host_req_i   (host_req),
    .host_we_i    (host_we),
    .host_addr_i  (host_addr),
    .host_wdata_i (host_wdata),
    .host_be_i    (host_be),
    .host_gnt_o   (host_gnt),
    .host_rvalid_o(host_rvalid),
    .host_rdata_o (host_rdata),
    .reg_valid_i  (reg_valid),
    .reg_write_i  (reg_write),
    .reg_addr_i   (reg_addr),
    .reg_wdata_i  (reg_wdata),
    .reg_rdata_o  (reg_rdata),
    .reg_ready_o  (reg_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  `include "tb_host_tasks.svh"

  // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
  function automatic harness_pkg::word_t rand_bits(input int unsigned n);
    harness_pkg::word_t val;
    logic               fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic stop_on_failure();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input harness_pkg::word_t exp,
                             input harness_pkg::word_t act);
    assert (act === exp) else begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      stop_on_failure();
    end
  endtask

  // Random write then random read within [base, base + span)
  task automatic host_pair(input int unsigned base, input int unsigned span);
    harness_pkg::word_t rd;
    harness_pkg::word_t wdata;
    harness_pkg::be_t   be;
    int unsigned        idx;
    idx   = base + rand_bits(9) % span;
    wdata = rand_bits(32);
    be    = harness_pkg::be_t'(rand_bits(4));
    host_access(1'b1, harness_pkg::word_t'(idx) << 2, wdata, be, rd);
    check_value("host write rdata", '0, rd);
    for (int b = 0; b < 4; b++) begin
      if (be[b]) model[idx][8*b +: 8] = wdata[8*b +: 8];
    end
    idx = base + rand_bits(9) % span;
    host_access(1'b0, harness_pkg::word_t'(idx) << 2, '0, '0, rd);
    check_value("host read", model[idx], rd);
  endtask

  task automatic start_copy(input int unsigned src, input int unsigned dst,
                            input int unsigned size);
    harness_pkg::word_t rd;
    reg_access(1'b1, reg_src_c, harness_pkg::word_t'(src) << 2, rd);
    reg_access(1'b1, reg_dst_c, harness_pkg::word_t'(dst) << 2, rd);
    reg_access(1'b1, reg_size_c, size, rd);
    reg_access(1'b1, reg_ctrl_c, 32'd1, rd);
  endtask

  // Poll CTRL until busy drops and apply the copy to the model
  task automatic finish_copy(input int unsigned src, input int unsigned dst,
                             input int unsigned size);
    harness_pkg::word_t rd;
    int unsigned        polls;
    rd    = 32'd1;
    polls = 0;
    while (rd[0]) begin
      if (polls >= poll_limit_c) begin
        $display("Timed out waiting for the copy engine to go idle");
        stop_on_failure();
      end else begin
        polls++;
        reg_access(1'b0, reg_ctrl_c, '0, rd);
      end
    end
    for (int i = 0; i < size; i++) model[dst + i] = model[src + i];
  endtask

  task automatic verify_memory(input string name);
    harness_pkg::word_t rd;
    for (int i = 0; i < mem_words_c; i++) begin
      host_access(1'b0, harness_pkg::word_t'(i) << 2, '0, '0, rd);
      check_value(name, model[i], rd);
    end
  endtask

  // Non-overlapping regions in opposite halves of the memory
  task automatic pick_regions(input int unsigned size, output int unsigned src,
                              output int unsigned dst);
    int unsigned lo;
    int unsigned hi;
    lo = rand_bits(8) % (257 - size);
    hi = 256 + rand_bits(8) % (257 - size);
    if (rand_bits(1)) begin
      src = hi;
      dst = lo;
    end else begin
      src = lo;
      dst = hi;
    end
  endtask

  initial begin
    harness_pkg::word_t rd;
    harness_pkg::word_t fill;
    harness_pkg::word_t regs [3];
    int unsigned        src;
    int unsigned        dst;
    int unsigned        size;
    lfsr       = 16'd63;
    reset      = 1'b1;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    host_be    = '0;
    reg_valid  = 1'b0;
    reg_write  = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;

    // Reset state
    repeat (8) begin
      @(negedge clk);
      check_value("reset host gnt", '0, host_gnt);
      check_value("reset host rvalid", '0, host_rvalid);
      check_value("reset reg ready", '0, reg_ready);
    end
    reset = 1'b0;
    @(negedge clk);
    check_value("after reset host gnt", '0, host_gnt);
    check_value("after reset host rvalid", '0, host_rvalid);
    check_value("after reset reg ready", '0, reg_ready);
    reg_access(1'b0, reg_ctrl_c, '0, rd);
    check_value("reset busy", '0, rd);

    // Known contents everywhere before random traffic
    for (int i = 0; i < mem_words_c; i++) begin
      fill = {16'hC3A5 ^ 16'(i << 2), 16'(i << 2)};
      host_access(1'b1, harness_pkg::word_t'(i) << 2, fill, 4'hF, rd);
      model[i] = fill;
    end

    repeat (200) host_pair(0, mem_words_c);

    // Register readback
    repeat (8) begin
      regs[0] = rand_bits(32);
      regs[1] = rand_bits(32);
      regs[2] = rand_bits(32);
      reg_access(1'b1, reg_src_c, regs[0], rd);
      reg_access(1'b1, reg_dst_c, regs[1], rd);
      reg_access(1'b1, reg_size_c, regs[2], rd);
      reg_access(1'b0, reg_src_c, '0, rd);
      check_value("register SRC", regs[0], rd);
      reg_access(1'b0, reg_dst_c, '0, rd);
      check_value("register DST", regs[1], rd);
      reg_access(1'b0, reg_size_c, '0, rd);
      check_value("register SIZE", regs[2], rd);
    end

    repeat (6) begin
      size = 1 + rand_bits(5);
      pick_regions(size, src, dst);
      start_copy(src, dst, size);
      finish_copy(src, dst, size);
      verify_memory("block copy");
    end

    // Host traffic above word 255 while a copy runs below it
    size = 32;
    src  = rand_bits(7) % 97;
    dst  = 128 + rand_bits(7) % 97;
    start_copy(src, dst, size);
    repeat (20) host_pair(256, 256);
    finish_copy(src, dst, size);
    verify_memory("concurrent traffic");

    // Register writes during a copy are dropped
    size = 16 + rand_bits(4);
    pick_regions(size, src, dst);
    start_copy(src, dst, size);
    reg_access(1'b1, reg_src_c, rand_bits(32), rd);
    reg_access(1'b1, reg_dst_c, rand_bits(32), rd);
    reg_access(1'b1, reg_size_c, rand_bits(32), rd);
    reg_access(1'b0, reg_ctrl_c, '0, rd);
    check_value("lockout busy", 32'd1, rd);
    finish_copy(src, dst, size);
    reg_access(1'b0, reg_src_c, '0, rd);
    check_value("lockout SRC", harness_pkg::word_t'(src) << 2, rd);
    reg_access(1'b0, reg_dst_c, '0, rd);
    check_value("lockout DST", harness_pkg::word_t'(dst) << 2, rd);
    reg_access(1'b0, reg_size_c, '0, rd);
    check_value("lockout SIZE", size, rd);
    verify_memory("lockout copy");

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// File: sources.f
+incdir+src
+incdir+tb
src/harness_pkg.sv
src/slow_memory.sv
src/obi_bank_router.sv
src/obi_resp_merge.sv
src/memcopy_periph.sv
src/testharness.sv
tb/tb_testharness.sv

// File: Bender.yml
package:
  name: testharness

sources:
  - include_dirs:
      - src
    files:
      - src/harness_pkg.sv
      - src/slow_memory.sv
      - src/obi_bank_router.sv
      - src/obi_resp_merge.sv
      - src/memcopy_periph.sv
      - src/testharness.sv
  - target: test
    include_dirs:
      - src
      - tb
    files:
      - tb/tb_testharness.sv
